// File: sources.f
+incdir+include
source/Qupls4_pkg.sv
source/Qupls4_decode_load.sv
source/Qupls4_decode_store.sv
source/Qupls4_decode_branch.sv
source/Qupls4_decode_alu.sv
source/Qupls4_decode_fields.sv
source/Qupls4_decode_ctrl.sv
source/Qupls4_decode_top.sv
dv/Qupls4_decode_asserts.sv
dv/Qupls4_decode_tb.sv

// File: dv/Qupls4_decode_tb.sv
// ==========================================================
// Random program testbench for the decode front end
// Memory answers after zero to three wait states
// About one word in eight carries an unlisted opcode
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_tb
	import Qupls4_pkg::*;
();

	localparam int numRecords = 400;
	localparam int cyclesPerRecord = 20;
	localparam int clkPeriodNs = 4;

	logic clk = 1'b0;
	logic rst, ack, decReady;
	logic [`QDEC_IW-1:0] datI;
	logic cyc, stb, decValid, illegal, load, loadZero, store, branch, alu;
	logic [`QDEC_AW-1:0] adr, pc;
	memSize_t loadSize, storeSize;
	brCond_t brCond;
	aluOp_t aluOp;
	logic [`QDEC_RW-1:0] rd, rs1, rs2;
	logic [`QDEC_IW-1:0] imm;

	// Memory model words by address and the order they were served in
	logic [`QDEC_IW-1:0] memWords [logic [`QDEC_AW-1:0]];
	logic [`QDEC_AW-1:0] servedAdrs [$];
	logic [`QDEC_AW-1:0] nextAdr, reqAdr;
	logic [`QDEC_IW-1:0] reqWord;
	logic reqActive, holding;
	int waitLeft, recordCount;
	logic [96:0] heldRecord;

	// Expected decode of the word being presented
	logic expIllegal, expLoad, expLoadZero, expStore, expBranch, expAlu;
	memSize_t expLoadSize, expStoreSize;
	brCond_t expBrCond;
	aluOp_t expAluOp;

	opcode_t validOps [20] = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LDB, OP_LDBZ,
		OP_LDW, OP_LDWZ, OP_LDT, OP_LDTZ, OP_LOAD, OP_STB, OP_STW, OP_STT, OP_STORE,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE};

	always #(clkPeriodNs / 2) clk = ~clk;

	Qupls4_decode_top i_dut (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .adr(adr), .datI(datI), .ack(ack),
		.decValid(decValid), .decReady(decReady), .pc(pc), .illegal(illegal),
		.load(load), .loadSize(loadSize), .loadZero(loadZero), .store(store),
		.storeSize(storeSize), .branch(branch), .brCond(brCond), .alu(alu),
		.aluOp(aluOp), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
	);

	// ========================================================
	// Failure reporting and value checks
	// ========================================================

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compareValue(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
			stopOnFailure($sformatf("error %s expected %0h got %0h", name, expected, actual));
	endtask

	function automatic logic opcodeListed(input logic [6:0] op);
		logic found;
		found = 1'b0;
		foreach (validOps[i])
			if (validOps[i] == op)
				found = 1'b1;
		return found;
	endfunction

	// Random upper bits with a mostly legal opcode in the low seven
	function automatic logic [`QDEC_IW-1:0] makeWord();
		logic [`QDEC_IW-1:0] word;
		logic [6:0] op;
		word = $urandom;
		if ($urandom % 8 == 0)
		begin
			op = 7'($urandom);
			while (opcodeListed(op))
				op = 7'($urandom);
		end
		else
			op = validOps[$urandom % 20];
		word[`QDEC_OP_HI:`QDEC_OP_LO] = op;
		return word;
	endfunction

	function automatic logic [96:0] packRecord();
		return {pc, illegal, load, loadSize, loadZero, store, storeSize,
			branch, brCond, alu, aluOp, rd, rs1, rs2, imm};
	endfunction

	// Reference decode straight from the opcode numbering
	task automatic predictDecode(input logic [`QDEC_IW-1:0] word);
		logic [6:0] op;
		op = word[`QDEC_OP_HI:`QDEC_OP_LO];
		{expLoad, expLoadZero, expStore, expBranch, expAlu} = '0;
		expLoadSize = SZ_BYTE;
		expStoreSize = SZ_BYTE;
		expBrCond = BR_EQ;
		expAluOp = ALU_NOP;
		// ALU ops 0 to 4 follow the aluOp order
		if (op <= 7'd4)
		begin
			expAlu = 1'b1;
			expAluOp = aluOp_t'(op[2:0]);
		end
		// Loads pair up by size and the odd member of each pair zero-extends
		else if (op >= 7'd16 && op <= 7'd22)
		begin
			expLoad = 1'b1;
			expLoadSize = (op == 7'd22) ? SZ_OCTA : memSize_t'(op[2:1]);
			expLoadZero = (op != 7'd22) && op[0];
		end
		else if (op >= 7'd24 && op <= 7'd27)
		begin
			expStore = 1'b1;
			expStoreSize = memSize_t'(op[1:0]);
		end
		else if (op >= 7'd32 && op <= 7'd35)
		begin
			expBranch = 1'b1;
			expBrCond = brCond_t'(op[1:0]);
		end
		// Illegal follows from the opcode list alone
		expIllegal = !opcodeListed(op);
	endtask

	task automatic checkRecord(input logic [`QDEC_IW-1:0] word);
		predictDecode(word);
		compareValue("illegal", expIllegal, illegal);
		compareValue("load", expLoad, load);
		compareValue("loadZero", expLoadZero, loadZero);
		compareValue("store", expStore, store);
		compareValue("branch", expBranch, branch);
		compareValue("alu", expAlu, alu);
		compareValue("aluOp", expAluOp, aluOp);
		// Size and condition only mean something inside their own class
		if (expLoad)
			compareValue("loadSize", expLoadSize, loadSize);
		if (expStore)
			compareValue("storeSize", expStoreSize, storeSize);
		if (expBranch)
			compareValue("brCond", expBrCond, brCond);
		compareValue("rd", word[12:7], rd);
		compareValue("rs1", word[18:13], rs1);
		compareValue("rs2", word[24:19], rs2);
		compareValue("imm", {{19{word[31]}}, word[31:19]}, imm);
	endtask

	// ========================================================
	// Memory model and consumer driven on the falling edge
	// ========================================================

	task automatic serveBus();
		ack = 1'b0;
		if (cyc && stb)
		begin
			if (!reqActive)
			begin
				// New request must sit at the next sequential address
				compareValue("adr", nextAdr, adr);
				reqActive = 1'b1;
				reqAdr = adr;
				reqWord = makeWord();
				waitLeft = $urandom % 4;
				memWords[adr] = reqWord;
				servedAdrs.push_back(adr);
			end
			else
				compareValue("adr", reqAdr, adr);
			if (waitLeft == 0)
			begin
				ack = 1'b1;
				datI = reqWord;
				reqActive = 1'b0;
				nextAdr = nextAdr + 32'd4;
			end
			else
			begin
				waitLeft = waitLeft - 1;
				datI = $urandom;
			end
		end
	endtask

	task automatic handleRecord();
		logic [`QDEC_AW-1:0] expAdr;
		if (decValid && cyc)
			stopOnFailure("a bus cycle started while a record was presented");
		if (decValid && !holding)
		begin
			// Each served word must appear exactly once
			if (servedAdrs.size() != 1)
				stopOnFailure("a record was presented without exactly one new fetched word");
			expAdr = servedAdrs.pop_front();
			compareValue("pc", expAdr, pc);
			checkRecord(memWords[expAdr]);
			heldRecord = packRecord();
			holding = 1'b1;
		end
		else if (decValid)
			compareValue("record", heldRecord, packRecord());
		else if (holding)
			stopOnFailure("decValid dropped before the record was taken");
		decReady = ($urandom % 2) == 1;
		if (decValid && decReady)
		begin
			holding = 1'b0;
			recordCount = recordCount + 1;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		ack = 1'b0;
		datI = '0;
		decReady = 1'b0;
		{reqActive, holding} = 2'b00;
		{nextAdr, reqAdr, reqWord} = '0;
		waitLeft = 0;
		recordCount = 0;
		void'($urandom(32'he95f1e7d));
		repeat (8) @(negedge clk);
		// Bus and handshake stay idle under reset
		compareValue("cyc", 1'b0, cyc);
		compareValue("stb", 1'b0, stb);
		compareValue("decValid", 1'b0, decValid);
		compareValue("pc", 32'd0, pc);
		rst = 1'b0;
		while (recordCount < numRecords)
		begin
			@(negedge clk);
			if (i_dut.i_asserts.assertFails != 0)
				stopOnFailure("a bound assertion on the bus or handshake failed");
			serveBus();
			handleRecord();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog sized from the record count with a generous per-record budget
	initial
	begin
		#(numRecords * cyclesPerRecord * clkPeriodNs);
		stopOnFailure("timeout: watchdog expired before all records were decoded");
	end

endmodule

`default_nettype wire

// File: dv/Qupls4_decode_asserts.sv
// ==========================================================
// Bus and handshake assertions bound into the decode top
// Checks are disabled while reset is applied
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_asserts
	import Qupls4_pkg::*;
(
	input wire logic                clk,
	input wire logic                rst,
	input wire logic                cyc,
	input wire logic                stb,
	input wire logic [`QDEC_AW-1:0] adr,
	input wire logic                ack,
	input wire logic                decValid,
	input wire logic                decReady,
	input wire logic [`QDEC_AW-1:0] pc,
	input wire logic                illegal,
	input wire logic                load,
	input wire memSize_t            loadSize,
	input wire logic                loadZero,
	input wire logic                store,
	input wire memSize_t            storeSize,
	input wire logic                branch,
	input wire brCond_t             brCond,
	input wire logic                alu,
	input wire aluOp_t              aluOp,
	input wire logic [`QDEC_RW-1:0] rd,
	input wire logic [`QDEC_RW-1:0] rs1,
	input wire logic [`QDEC_RW-1:0] rs2,
	input wire logic [`QDEC_IW-1:0] imm
);

	// Whole presented record packed into one vector for the stability check
	logic [96:0] record;

	// Number of assertion failures so far
	int assertFails = 0;

	assign record = {pc, illegal, load, loadSize, loadZero, store, storeSize,
		branch, brCond, alu, aluOp, rd, rs1, rs2, imm};

	// Strobe never appears outside a bus cycle
	stbImpliesCyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
		else
		begin
			$error("stb high without cyc");
			assertFails++;
		end

	// A request keeps its address until the slave acknowledges it
	adrStable: assert property (@(posedge clk) disable iff (rst)
		cyc && !ack |=> cyc && $stable(adr))
		else
		begin
			$error("adr or cyc changed before ack");
			assertFails++;
		end

	// Back-pressure freezes the whole record
	recordHeld: assert property (@(posedge clk) disable iff (rst)
		decValid && !decReady |=> decValid && $stable(record))
		else
		begin
			$error("record changed while decReady was low");
			assertFails++;
		end

	// Only one instruction is in flight so no fetch starts while presenting
	noFetchWhilePresent: assert property (@(posedge clk) disable iff (rst)
		decValid |-> !cyc)
		else
		begin
			$error("bus cycle started while a record was presented");
			assertFails++;
		end

endmodule

bind Qupls4_decode_top Qupls4_decode_asserts i_asserts (
	.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .adr(adr), .ack(ack),
	.decValid(decValid), .decReady(decReady), .pc(pc), .illegal(illegal),
	.load(load), .loadSize(loadSize), .loadZero(loadZero), .store(store),
	.storeSize(storeSize), .branch(branch), .brCond(brCond), .alu(alu),
	.aluOp(aluOp), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
);

`default_nettype wire

// File: source/Qupls4_decode_top.sv
// ==========================================================
// Decode front end top level
// Decode outputs are meaningful only while decValid is high
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_top
	import Qupls4_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst,
	output logic                     cyc,
	output logic                     stb,
	output logic [`QDEC_AW-1:0]      adr,
	input  wire logic [`QDEC_IW-1:0] datI,
	input  wire logic                ack,
	output logic                     decValid,
	input  wire logic                decReady,
	output logic [`QDEC_AW-1:0]      pc,
	output logic                     illegal,
	output logic                     load,
	output memSize_t                 loadSize,
	output logic                     loadZero,
	output logic                     store,
	output memSize_t                 storeSize,
	output logic                     branch,
	output brCond_t                  brCond,
	output logic                     alu,
	output aluOp_t                   aluOp,
	output logic [`QDEC_RW-1:0]      rd,
	output logic [`QDEC_RW-1:0]      rs1,
	output logic [`QDEC_RW-1:0]      rs2,
	output logic [`QDEC_IW-1:0]      imm
);

	// Instruction register shared by every decoder
	logic [`QDEC_IW-1:0] instr;

	Qupls4_decode_ctrl i_ctrl (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .adr(adr), .datI(datI), .ack(ack),
		.instr(instr), .load(load), .store(store), .branch(branch), .alu(alu),
		.illegal(illegal), .pc(pc), .decValid(decValid), .decReady(decReady)
	);

	// Class decoders work on the opcode field of the same word
	Qupls4_decode_load i_load (.instr(instr), .load(load), .loadSize(loadSize), .loadZero(loadZero));
	Qupls4_decode_store i_store (.instr(instr), .store(store), .storeSize(storeSize));
	Qupls4_decode_branch i_branch (.instr(instr), .branch(branch), .brCond(brCond));
	Qupls4_decode_alu i_alu (.instr(instr), .alu(alu), .aluOp(aluOp));

	Qupls4_decode_fields i_fields (.instr(instr), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm));

endmodule

`default_nettype wire

// File: source/Qupls4_decode_ctrl.sv
// ==========================================================
// Fetch and present control, one instruction in flight
// Wishbone classic read only, no err or rty support
// Fetch starts at address zero and steps by four
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_ctrl
	import Qupls4_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst,
	// Wishbone classic master port
	output logic                     cyc,
	output logic                     stb,
	output logic [`QDEC_AW-1:0]      adr,
	input  wire logic [`QDEC_IW-1:0] datI,
	input  wire logic                ack,
	// Instruction register and class flags from the decoders
	output logic [`QDEC_IW-1:0]      instr,
	input  wire logic                load,
	input  wire logic                store,
	input  wire logic                branch,
	input  wire logic                alu,
	output logic                     illegal,
	// Decoded record handshake
	output logic [`QDEC_AW-1:0]      pc,
	output logic                     decValid,
	input  wire logic                decReady
);

	fetchState_t state;

	// ========================================================
	// Fetch state machine
	// ========================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			pc    <= '0;
		end
		else
		begin
			case (state)
			// Single cycle after reset before the first request
			ST_IDLE:
				state <= ST_FETCH;
			// Wait out the slave until it acknowledges
			ST_FETCH:
				if (ack)
					state <= ST_PRESENT;
			// Hold the record until the consumer takes it
			ST_PRESENT:
				if (decReady)
				begin
					state <= ST_FETCH;
					pc    <= pc + `QDEC_AW'(4);
				end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// The instruction word is captured on the acknowledge cycle
	always_ff @(posedge clk)
	begin
		if (state == ST_FETCH && ack)
			instr <= datI;
	end

	// ========================================================
	// Bus and handshake outputs
	// ========================================================

	// Strobe and cycle are asserted together for the whole request
	assign cyc = (state == ST_FETCH);
	assign stb = (state == ST_FETCH);

	// Address only moves on a transfer so it is stable through a request
	assign adr = pc;

	assign decValid = (state == ST_PRESENT);

	// A word that no class decoder claims is illegal
	assign illegal = ~(load | store | branch | alu);

endmodule

`default_nettype wire

// File: source/Qupls4_decode_fields.sv
// ==========================================================
// Register field and immediate extractor
// Fields are produced for every word whatever the opcode
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_fields
	import Qupls4_pkg::*;
(
	input  wire logic [`QDEC_IW-1:0] instr,
	output logic [`QDEC_RW-1:0]      rd,
	output logic [`QDEC_RW-1:0]      rs1,
	output logic [`QDEC_RW-1:0]      rs2,
	output logic [`QDEC_IW-1:0]      imm
);

	// Register numbers are plain slices of the word
	assign rd  = instr[`QDEC_RD_HI:`QDEC_RD_LO];
	assign rs1 = instr[`QDEC_RS1_HI:`QDEC_RS1_LO];
	assign rs2 = instr[`QDEC_RS2_HI:`QDEC_RS2_LO];

	// The immediate overlaps rs2 and is sign-extended from its top bit
	assign imm = {{(`QDEC_IW-`QDEC_IMM_W){instr[`QDEC_IMM_HI]}},
		instr[`QDEC_IMM_HI:`QDEC_IMM_LO]};

endmodule

`default_nettype wire

// File: source/Qupls4_decode_alu.sv
// ==========================================================
// ALU class decoder, purely combinational
// NOP counts as an ALU instruction
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_alu
	import Qupls4_pkg::*;
(
	input  wire logic [`QDEC_IW-1:0] instr,
	output logic                     alu,
	output aluOp_t                   aluOp
);

	opcode_t op;

	assign op = opcode_t'(instr[`QDEC_OP_HI:`QDEC_OP_LO]);

	always_comb
	begin
		// aluOp stays at ALU_NOP for anything outside the ALU class
		alu   = 1'b0;
		aluOp = ALU_NOP;
		case (op)
		OP_NOP: alu = 1'b1;
		OP_ADD: begin alu = 1'b1; aluOp = ALU_ADD; end
		OP_SUB: begin alu = 1'b1; aluOp = ALU_SUB; end
		OP_AND: begin alu = 1'b1; aluOp = ALU_AND; end
		OP_OR:  begin alu = 1'b1; aluOp = ALU_OR; end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/Qupls4_decode_branch.sv
// ==========================================================
// Conditional branch decoder, purely combinational
// brCond is don't-care when branch is low
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_branch
	import Qupls4_pkg::*;
(
	input  wire logic [`QDEC_IW-1:0] instr,
	output logic                     branch,
	output brCond_t                  brCond
);

	opcode_t op;

	assign op = opcode_t'(instr[`QDEC_OP_HI:`QDEC_OP_LO]);

	always_comb
	begin
		branch = 1'b0;
		brCond = BR_EQ;
		// Each branch opcode maps to exactly one condition
		case (op)
		OP_BEQ: begin branch = 1'b1; brCond = BR_EQ; end
		OP_BNE: begin branch = 1'b1; brCond = BR_NE; end
		OP_BLT: begin branch = 1'b1; brCond = BR_LT; end
		OP_BGE: begin branch = 1'b1; brCond = BR_GE; end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/Qupls4_decode_store.sv
// ==========================================================
// Store class decoder, purely combinational
// storeSize is don't-care when store is low
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_store
	import Qupls4_pkg::*;
(
	input  wire logic [`QDEC_IW-1:0] instr,
	output logic                     store,
	output memSize_t                 storeSize
);

	opcode_t op;

	assign op = opcode_t'(instr[`QDEC_OP_HI:`QDEC_OP_LO]);

	always_comb
	begin
		store     = 1'b0;
		storeSize = SZ_BYTE;
		// Sizes follow the same ordering as the load forms
		case (op)
		OP_STB:   begin store = 1'b1; storeSize = SZ_BYTE; end
		OP_STW:   begin store = 1'b1; storeSize = SZ_WYDE; end
		OP_STT:   begin store = 1'b1; storeSize = SZ_TETRA; end
		OP_STORE: begin store = 1'b1; storeSize = SZ_OCTA; end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/Qupls4_decode_load.sv
// ==========================================================
// Load class decoder, purely combinational
// Outputs are don't-care when load is low
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "Qupls4_decode_defs.svh"

module Qupls4_decode_load
	import Qupls4_pkg::*;
(
	input  wire logic [`QDEC_IW-1:0] instr,
	output logic                     load,
	output memSize_t                 loadSize,
	output logic                     loadZero
);

	opcode_t op;

	// Only the opcode field matters to this decoder
	assign op = opcode_t'(instr[`QDEC_OP_HI:`QDEC_OP_LO]);

	always_comb
	begin
		// Defaults cover every non-load opcode
		load     = 1'b0;
		loadSize = SZ_BYTE;
		loadZero = 1'b0;
		case (op)
		OP_LDB:  begin load = 1'b1; loadSize = SZ_BYTE; end
		OP_LDBZ: begin load = 1'b1; loadSize = SZ_BYTE; loadZero = 1'b1; end
		OP_LDW:  begin load = 1'b1; loadSize = SZ_WYDE; end
		OP_LDWZ: begin load = 1'b1; loadSize = SZ_WYDE; loadZero = 1'b1; end
		OP_LDT:  begin load = 1'b1; loadSize = SZ_TETRA; end
		OP_LDTZ: begin load = 1'b1; loadSize = SZ_TETRA; loadZero = 1'b1; end
		// Full width load has nothing to extend
		OP_LOAD: begin load = 1'b1; loadSize = SZ_OCTA; end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/Qupls4_pkg.sv
// ==========================================================
// Shared types for the decode front end
// Opcode values outside opcode_t are treated as illegal
// ==========================================================
`default_nettype none

package Qupls4_pkg;

	// Primary opcodes held in the low seven bits of the word
	typedef enum logic [6:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd1,
		OP_SUB   = 7'd2,
		OP_AND   = 7'd3,
		OP_OR    = 7'd4,
		OP_LDB   = 7'd16,
		OP_LDBZ  = 7'd17,
		OP_LDW   = 7'd18,
		OP_LDWZ  = 7'd19,
		OP_LDT   = 7'd20,
		OP_LDTZ  = 7'd21,
		OP_LOAD  = 7'd22,
		OP_STB   = 7'd24,
		OP_STW   = 7'd25,
		OP_STT   = 7'd26,
		OP_STORE = 7'd27,
		OP_BEQ   = 7'd32,
		OP_BNE   = 7'd33,
		OP_BLT   = 7'd34,
		OP_BGE   = 7'd35
	} opcode_t;

	// Memory access sizes from byte up to octa
	typedef enum logic [1:0] {SZ_BYTE, SZ_WYDE, SZ_TETRA, SZ_OCTA} memSize_t;

	// ALU operations selected by the ALU decoder
	typedef enum logic [2:0] {ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} aluOp_t;

	// Conditions tested by a conditional branch
	typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} brCond_t;

	// States of the fetch machine in the control module
	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_PRESENT} fetchState_t;

endpackage

`default_nettype wire

// File: include/Qupls4_decode_defs.svh
// ==========================================================
// Instruction word layout for the decode front end
// Immediate shares its low bits with the rs2 field
// ==========================================================
`ifndef QUPLS4_DECODE_DEFS_SVH
`define QUPLS4_DECODE_DEFS_SVH

// Word, register number and bus address widths
`define QDEC_IW		32
`define QDEC_RW		6
`define QDEC_AW		32
`define QDEC_IMM_W	13

// Bit positions of each instruction field
`define QDEC_OP_HI	6
`define QDEC_OP_LO	0
`define QDEC_RD_HI	12
`define QDEC_RD_LO	7
`define QDEC_RS1_HI	18
`define QDEC_RS1_LO	13
`define QDEC_RS2_HI	24
`define QDEC_RS2_LO	19
`define QDEC_IMM_HI	31
`define QDEC_IMM_LO	19

`endif
